//--- design/memUnit_defs.svh
`ifndef MEMUNIT_DEFS_SVH
`define MEMUNIT_DEFS_SVH

// Address-generation ports feeding the memory unit
`define NUM_AGUS 2

// Load buffer slots, must be a power of two
`define LB_SIZE 8

`define SQN_BITS 7

// Uncached I/O window, both bounds inclusive
`define MMIO_BASE 32'h1000_0000
`define MMIO_TOP 32'h1FFF_FFFF

`endif

//--- design/memUnitPkg.sv
`default_nettype none

`include "memUnit_defs.svh"

package memUnitPkg;

    // Sequence numbers wrap, so order is always taken from a signed difference
    typedef logic [`SQN_BITS-1:0] SqN;
    typedef logic [6:0] Tag;
    typedef logic [31:0] MemAddr;
    typedef logic [1:0] AccessSize;
    typedef logic [$clog2(`LB_SIZE)-1:0] SlotIdx;

    typedef enum logic [1:0] {
        AGU_NO_EXCEPTION,
        AGU_ADDR_MISALIGN,
        AGU_ACCESS_FAULT
    } AguExc;

    // Accesses are naturally aligned, so a common word plus the size code decides the overlap
    function automatic logic accessOverlap(
        input MemAddr stAddr,
        input AccessSize stSize,
        input MemAddr ldAddr,
        input AccessSize ldSize
    );
        logic sameWord;
        sameWord = stAddr[31:2] == ldAddr[31:2];
        return sameWord && (stSize == 2'd2 ||
            (stSize == 2'd1 && (ldSize > 2'd1 || ldAddr[1] == stAddr[1])) ||
            (stSize == 2'd0 && (ldSize > 2'd0 || ldAddr[1:0] == stAddr[1:0])));
    endfunction

    function automatic logic isMmioAddr(input MemAddr addr);
        return addr >= `MMIO_BASE && addr <= `MMIO_TOP;
    endfunction

endpackage

`default_nettype wire

//--- design/aguOpIf.sv
`timescale 1ns/10ps
`default_nettype none

// One load or store per cycle, present only while valid is high
interface aguOpIf;
    import memUnitPkg::*;

    logic valid;
    logic isLoad;
    MemAddr addr;
    AccessSize size;
    logic signExtend;
    SqN sqN;
    SqN loadSqN;
    Tag tagDst;
    logic doNotCommit;
    logic earlyFail;
    AguExc exc;
    MemAddr pc;
    logic compressed;

    modport producer (
        output valid, isLoad, addr, size, signExtend, sqN, loadSqN, tagDst,
        output doNotCommit, earlyFail, exc, pc, compressed
    );
    modport consumer (
        input valid, isLoad, addr, size, signExtend, sqN, loadSqN, tagDst,
        input doNotCommit, earlyFail, exc, pc, compressed
    );
endinterface

`default_nettype wire

//--- design/loadIssueIf.sv
`timescale 1ns/10ps
`default_nettype none

// Load request toward the cache. A late request holds while valid and stall are both high
interface loadIssueIf;
    import memUnitPkg::*;

    logic valid;
    MemAddr addr;
    AccessSize size;
    logic signExtend;
    SqN loadSqN;
    SqN sqN;
    Tag tagDst;
    logic doNotCommit;
    AguExc exc;
    logic isMmio;
    logic stall;

    modport issuer (
        output valid, addr, size, signExtend, loadSqN, sqN, tagDst, doNotCommit, exc, isMmio,
        input stall
    );
    modport cache (
        input valid, addr, size, signExtend, loadSqN, sqN, tagDst, doNotCommit, exc, isMmio,
        output stall
    );
endinterface

`default_nettype wire

//--- design/forwardHazardDetect.sv
`timescale 1ns/10ps
`default_nettype none

`include "memUnit_defs.svh"

module forwardHazardDetect (
    aguOpIf.consumer agu[`NUM_AGUS],
    output logic delayLoad[`NUM_AGUS],
    output logic nonSpec[`NUM_AGUS]
);
    import memUnitPkg::*;

    logic valid[`NUM_AGUS];
    logic isLoad[`NUM_AGUS];
    logic dnc[`NUM_AGUS];
    logic earlyFail[`NUM_AGUS];
    MemAddr addr[`NUM_AGUS];
    AccessSize size[`NUM_AGUS];
    SqN loadSqN[`NUM_AGUS];
    AguExc exc[`NUM_AGUS];

    for (genvar g = 0; g < `NUM_AGUS; g++) begin : gPort
        assign valid[g] = agu[g].valid;
        assign isLoad[g] = agu[g].isLoad;
        assign dnc[g] = agu[g].doNotCommit;
        assign earlyFail[g] = agu[g].earlyFail;
        assign addr[g] = agu[g].addr;
        assign size[g] = agu[g].size;
        assign loadSqN[g] = agu[g].loadSqN;
        assign exc[g] = agu[g].exc;
    end

    always_comb begin
        for (int h = 0; h < `NUM_AGUS; h++) begin
            nonSpec[h] = valid[h] && isLoad[h] && isMmioAddr(addr[h]) &&
                exc[h] == AGU_NO_EXCEPTION;
            delayLoad[h] = nonSpec[h] || earlyFail[h];

            // A store issued alongside that is not younger would need its data forwarded
            for (int i = 0; i < `NUM_AGUS; i++) begin
                if (i != h && valid[h] && isLoad[h] && valid[i] && !isLoad[i] &&
                    $signed(loadSqN[i] - loadSqN[h]) <= 0 &&
                    (!dnc[i] || loadSqN[i] != loadSqN[h]) &&
                    exc[h] == AGU_NO_EXCEPTION &&
                    accessOverlap(addr[i], size[i], addr[h], size[h]))
                    delayLoad[h] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/lateIssueSelect.sv
`timescale 1ns/10ps
`default_nettype none

`include "memUnit_defs.svh"

module lateIssueSelect (
    input wire logic [`LB_SIZE-1:0] pending,
    input wire logic [`LB_SIZE-1:0] nonSpec,
    input wire memUnitPkg::SlotIdx deqSlot,
    input wire memUnitPkg::SqN headSqN,
    input wire memUnitPkg::SqN comSqN,
    input wire logic sqDone,
    output memUnitPkg::SlotIdx pick,
    output logic pickValid
);
    import memUnitPkg::*;

    always_comb begin
        SlotIdx idx;
        pick = deqSlot;
        pickValid = 1'b0;

        // Oldest speculative load first, counting from the head
        for (int i = 0; i < `LB_SIZE; i++) begin
            idx = deqSlot + SlotIdx'(i);
            if (!pickValid && pending[idx] && !nonSpec[idx]) begin
                pickValid = 1'b1;
                pick = idx;
            end
        end

        // The head always wins. MMIO loads wait until everything older has committed
        if (pending[deqSlot] && (!nonSpec[deqSlot] || (headSqN == comSqN && sqDone))) begin
            pickValid = 1'b1;
            pick = deqSlot;
        end
    end

endmodule

`default_nettype wire

//--- design/squashMaskGen.sv
`timescale 1ns/10ps
`default_nettype none

`include "memUnit_defs.svh"

module squashMaskGen (
    input wire logic brTaken,
    input wire memUnitPkg::SqN brLoadSqN,
    input wire memUnitPkg::SqN baseSqN,
    input wire memUnitPkg::SqN lastBaseSqN,
    output logic [`LB_SIZE-1:0] mask
);
    import memUnitPkg::*;

    SlotIdx startSlot;
    SlotIdx endSlot;

    assign startSlot = brTaken ? SlotIdx'(brLoadSqN) : SlotIdx'(lastBaseSqN);
    assign endSlot = SlotIdx'(baseSqN);

    always_comb begin
        logic active;
        // Start already active when the range wraps past the last slot.
        // A branch at the head slot clears the whole buffer, an unchanged base clears nothing
        active = brTaken ? (endSlot <= startSlot) : (endSlot < startSlot);
        for (int i = 0; i < `LB_SIZE; i++) begin
            if (brTaken) begin
                if (i == startSlot)
                    active = 1'b1;
                else if (i == endSlot)
                    active = 1'b0;
            end else begin
                if (i == endSlot)
                    active = 1'b0;
                else if (i == startSlot)
                    active = 1'b1;
            end
            mask[i] = active;
        end
    end

endmodule

`default_nettype wire

//--- design/loadBuffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "memUnit_defs.svh"

module loadBuffer (
    input wire logic clk,
    input wire logic rst,
    aguOpIf.consumer agu[`NUM_AGUS],
    loadIssueIf.issuer early[`NUM_AGUS],
    loadIssueIf.issuer late[`NUM_AGUS],
    input wire logic ackValid[`NUM_AGUS],
    input wire logic ackFail[`NUM_AGUS],
    input wire memUnitPkg::SqN ackLoadSqN[`NUM_AGUS],
    input wire memUnitPkg::SqN comLoadSqN,
    input wire memUnitPkg::SqN comSqN,
    input wire logic sqDone,
    input wire logic brTaken,
    input wire logic brFlush,
    input wire memUnitPkg::SqN brSqN,
    input wire memUnitPkg::SqN brLoadSqN,
    output logic redirTaken,
    output memUnitPkg::MemAddr redirPc,
    output memUnitPkg::SqN redirSqN,
    output memUnitPkg::SqN redirLoadSqN,
    output memUnitPkg::SqN maxLoadSqN
);
    import memUnitPkg::*;

    localparam int IDX_BITS = $clog2(`LB_SIZE);
    localparam int HI_BITS = `SQN_BITS - IDX_BITS;

    // Entry storage, the slot index supplies the low loadSqN bits
    SqN eSqN[`LB_SIZE];
    Tag eTag[`LB_SIZE];
    logic [HI_BITS-1:0] eHi[`LB_SIZE];
    MemAddr eAddr[`LB_SIZE];
    AccessSize eSize[`LB_SIZE];
    logic eSignExt[`LB_SIZE];
    logic eDnc[`LB_SIZE];
    logic [`LB_SIZE-1:0] eNonSpec;
    logic [`LB_SIZE-1:0] eIssued;
    logic [`LB_SIZE-1:0] eValid;

    logic aValid[`NUM_AGUS];
    logic aIsLoad[`NUM_AGUS];
    logic aSignExt[`NUM_AGUS];
    logic aDnc[`NUM_AGUS];
    logic aCompressed[`NUM_AGUS];
    MemAddr aAddr[`NUM_AGUS];
    MemAddr aPc[`NUM_AGUS];
    AccessSize aSize[`NUM_AGUS];
    SqN aSqN[`NUM_AGUS];
    SqN aLoadSqN[`NUM_AGUS];
    Tag aTag[`NUM_AGUS];
    AguExc aExc[`NUM_AGUS];

    logic lValid[`NUM_AGUS];
    logic lSignExt[`NUM_AGUS];
    logic lDnc[`NUM_AGUS];
    logic lMmio[`NUM_AGUS];
    MemAddr lAddr[`NUM_AGUS];
    AccessSize lSize[`NUM_AGUS];
    SqN lLoadSqN[`NUM_AGUS];
    SqN lSqN[`NUM_AGUS];
    Tag lTag[`NUM_AGUS];
    AguExc lExc[`NUM_AGUS];
    logic lateStall[`NUM_AGUS];

    logic delayLoad[`NUM_AGUS];
    logic nonSpec[`NUM_AGUS];
    logic storeConflict[`NUM_AGUS];
    SlotIdx deqSlot;
    SlotIdx pick;
    logic pickValid;
    logic [`LB_SIZE-1:0] squashMask;
    logic brFar;
    SqN lastBaseSqN;

    assign deqSlot = SlotIdx'(comLoadSqN);
    assign brFar = $signed(brLoadSqN - comLoadSqN) >= `LB_SIZE;

    for (genvar g = 0; g < `NUM_AGUS; g++) begin : gPort
        assign aValid[g] = agu[g].valid;
        assign aIsLoad[g] = agu[g].isLoad;
        assign aSignExt[g] = agu[g].signExtend;
        assign aDnc[g] = agu[g].doNotCommit;
        assign aCompressed[g] = agu[g].compressed;
        assign aAddr[g] = agu[g].addr;
        assign aPc[g] = agu[g].pc;
        assign aSize[g] = agu[g].size;
        assign aSqN[g] = agu[g].sqN;
        assign aLoadSqN[g] = agu[g].loadSqN;
        assign aTag[g] = agu[g].tagDst;
        assign aExc[g] = agu[g].exc;
        assign lateStall[g] = late[g].stall;

        assign early[g].valid = aValid[g] && aIsLoad[g] && !delayLoad[g];
        assign early[g].addr = aAddr[g];
        assign early[g].size = aSize[g];
        assign early[g].signExtend = aSignExt[g];
        assign early[g].loadSqN = aLoadSqN[g];
        assign early[g].sqN = aSqN[g];
        assign early[g].tagDst = aTag[g];
        assign early[g].doNotCommit = aDnc[g];
        assign early[g].exc = aExc[g];
        assign early[g].isMmio = isMmioAddr(aAddr[g]);

        assign late[g].valid = lValid[g];
        assign late[g].addr = lAddr[g];
        assign late[g].size = lSize[g];
        assign late[g].signExtend = lSignExt[g];
        assign late[g].loadSqN = lLoadSqN[g];
        assign late[g].sqN = lSqN[g];
        assign late[g].tagDst = lTag[g];
        assign late[g].doNotCommit = lDnc[g];
        assign late[g].exc = lExc[g];
        assign late[g].isMmio = lMmio[g];
    end

    forwardHazardDetect forwardHazardDetect_i (
        .agu(agu),
        .delayLoad(delayLoad),
        .nonSpec(nonSpec)
    );

    lateIssueSelect lateIssueSelect_i (
        .pending(eValid & ~eIssued),
        .nonSpec(eNonSpec),
        .deqSlot(deqSlot),
        .headSqN(eSqN[deqSlot]),
        .comSqN(comSqN),
        .sqDone(sqDone),
        .pick(pick),
        .pickValid(pickValid)
    );

    squashMaskGen squashMaskGen_i (
        .brTaken(brTaken),
        .brLoadSqN(brLoadSqN),
        .baseSqN(comLoadSqN),
        .lastBaseSqN(lastBaseSqN),
        .mask(squashMask)
    );

    // A store hitting a younger load that already read memory means that load saw stale data
    always_comb begin
        SqN entLoadSqN;
        for (int h = 0; h < `NUM_AGUS; h++) begin
            storeConflict[h] = 1'b0;
            for (int i = 0; i < `LB_SIZE; i++) begin
                entLoadSqN = {eHi[i], SlotIdx'(i)};
                if (eValid[i] && eIssued[i] && $signed(aLoadSqN[h] - entLoadSqN) <= 0 &&
                    (!aDnc[h] || aLoadSqN[h] != entLoadSqN) &&
                    accessOverlap(aAddr[h], aSize[h], eAddr[i], eSize[i]))
                    storeConflict[h] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        logic [`NUM_AGUS-1:0] passthru;
        SlotIdx slot;
        passthru = '0;
        lastBaseSqN <= comLoadSqN;
        maxLoadSqN <= comLoadSqN + SqN'(`LB_SIZE - 1);
        redirTaken <= 1'b0;

        if (rst) begin
            eValid <= '0;
            for (int p = 0; p < `NUM_AGUS; p++)
                lValid[p] <= 1'b0;
        end else begin
            for (int p = 0; p < `NUM_AGUS; p++) begin
                if (!lateStall[p])
                    lValid[p] <= 1'b0;
                if (ackValid[p] && ackFail[p])
                    eIssued[SlotIdx'(ackLoadSqN[p])] <= 1'b0;
            end

            if (brTaken) begin
                for (int i = 0; i < `LB_SIZE; i++)
                    if ((squashMask[i] && !brFar) || brFlush)
                        eValid[i] <= 1'b0;
                for (int p = 0; p < `NUM_AGUS; p++)
                    if ($signed(lSqN[p] - brSqN) > 0 || brFlush)
                        lValid[p] <= 1'b0;
            end else begin
                for (int p = 0; p < `NUM_AGUS; p++) begin
                    if (!lValid[p] || !lateStall[p]) begin
                        // Buffered loads reissue on port 0 only
                        if (p == 0 && pickValid) begin
                            eIssued[pick] <= 1'b1;
                            lAddr[p] <= eAddr[pick];
                            lSize[p] <= eSize[pick];
                            lSignExt[p] <= eSignExt[pick];
                            lLoadSqN[p] <= {eHi[pick], pick};
                            lSqN[p] <= eSqN[pick];
                            lTag[p] <= eTag[pick];
                            lDnc[p] <= eDnc[pick];
                            lExc[p] <= AGU_NO_EXCEPTION;
                            lMmio[p] <= isMmioAddr(eAddr[pick]);
                            lValid[p] <= 1'b1;
                        end else if (aValid[p] && aIsLoad[p] && delayLoad[p] && !nonSpec[p]) begin
                            lAddr[p] <= aAddr[p];
                            lSize[p] <= aSize[p];
                            lSignExt[p] <= aSignExt[p];
                            lLoadSqN[p] <= aLoadSqN[p];
                            lSqN[p] <= aSqN[p];
                            lTag[p] <= aTag[p];
                            lDnc[p] <= aDnc[p];
                            lExc[p] <= aExc[p];
                            lMmio[p] <= 1'b0;
                            lValid[p] <= 1'b1;
                            passthru[p] = 1'b1;
                        end
                    end
                end
                for (int i = 0; i < `LB_SIZE; i++)
                    if (squashMask[i])
                        eValid[i] <= 1'b0;
            end

            for (int p = 0; p < `NUM_AGUS; p++) begin
                if (aValid[p] && (!brTaken || $signed(aSqN[p] - brSqN) <= 0)) begin
                    if (aIsLoad[p]) begin
                        slot = SlotIdx'(aLoadSqN[p]);
                        eSqN[slot] <= aSqN[p];
                        eTag[slot] <= aTag[p];
                        eHi[slot] <= aLoadSqN[p][`SQN_BITS-1:IDX_BITS];
                        eAddr[slot] <= aAddr[p];
                        eSize[slot] <= aSize[p];
                        eSignExt[slot] <= aSignExt[p];
                        eDnc[slot] <= aDnc[p];
                        eNonSpec[slot] <= nonSpec[p];
                        eIssued[slot] <= !delayLoad[p] || passthru[p];
                        eValid[slot] <= 1'b1;
                    end else if (storeConflict[p]) begin
                        // Restart right after the store, which covers every younger load
                        redirTaken <= 1'b1;
                        redirPc <= aPc[p] + (aCompressed[p] ? 32'd2 : 32'd4);
                        redirSqN <= aSqN[p];
                        redirLoadSqN <= aLoadSqN[p] + SqN'(aDnc[p]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/memLoadUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "memUnit_defs.svh"

module memLoadUnit (
    input wire logic clk,
    input wire logic rst,
    input wire logic aguValid[`NUM_AGUS],
    input wire logic aguIsLoad[`NUM_AGUS],
    input wire memUnitPkg::MemAddr aguAddr[`NUM_AGUS],
    input wire memUnitPkg::AccessSize aguSize[`NUM_AGUS],
    input wire logic aguSignExtend[`NUM_AGUS],
    input wire memUnitPkg::SqN aguSqN[`NUM_AGUS],
    input wire memUnitPkg::SqN aguLoadSqN[`NUM_AGUS],
    input wire memUnitPkg::Tag aguTag[`NUM_AGUS],
    input wire logic aguDoNotCommit[`NUM_AGUS],
    input wire logic aguEarlyFail[`NUM_AGUS],
    input wire memUnitPkg::AguExc aguExc[`NUM_AGUS],
    input wire memUnitPkg::MemAddr aguPc[`NUM_AGUS],
    input wire logic aguCompressed[`NUM_AGUS],
    input wire logic ackValid[`NUM_AGUS],
    input wire logic ackFail[`NUM_AGUS],
    input wire memUnitPkg::SqN ackLoadSqN[`NUM_AGUS],
    input wire logic stall[`NUM_AGUS],
    input wire memUnitPkg::SqN comLoadSqN,
    input wire memUnitPkg::SqN comSqN,
    input wire logic sqDone,
    input wire logic brTaken,
    input wire logic brFlush,
    input wire memUnitPkg::SqN brSqN,
    input wire memUnitPkg::SqN brLoadSqN,
    output logic earlyValid[`NUM_AGUS],
    output memUnitPkg::MemAddr earlyAddr[`NUM_AGUS],
    output memUnitPkg::AccessSize earlySize[`NUM_AGUS],
    output memUnitPkg::SqN earlyLoadSqN[`NUM_AGUS],
    output memUnitPkg::Tag earlyTag[`NUM_AGUS],
    output logic lateValid[`NUM_AGUS],
    output memUnitPkg::MemAddr lateAddr[`NUM_AGUS],
    output memUnitPkg::AccessSize lateSize[`NUM_AGUS],
    output memUnitPkg::SqN lateLoadSqN[`NUM_AGUS],
    output memUnitPkg::Tag lateTag[`NUM_AGUS],
    output logic lateIsMmio[`NUM_AGUS],
    output logic redirTaken,
    output memUnitPkg::MemAddr redirPc,
    output memUnitPkg::SqN redirSqN,
    output memUnitPkg::SqN redirLoadSqN,
    output memUnitPkg::SqN maxLoadSqN
);
    aguOpIf agu[`NUM_AGUS]();
    loadIssueIf early[`NUM_AGUS]();
    loadIssueIf late[`NUM_AGUS]();

    for (genvar g = 0; g < `NUM_AGUS; g++) begin : gPort
        assign agu[g].valid = aguValid[g];
        assign agu[g].isLoad = aguIsLoad[g];
        assign agu[g].addr = aguAddr[g];
        assign agu[g].size = aguSize[g];
        assign agu[g].signExtend = aguSignExtend[g];
        assign agu[g].sqN = aguSqN[g];
        assign agu[g].loadSqN = aguLoadSqN[g];
        assign agu[g].tagDst = aguTag[g];
        assign agu[g].doNotCommit = aguDoNotCommit[g];
        assign agu[g].earlyFail = aguEarlyFail[g];
        assign agu[g].exc = aguExc[g];
        assign agu[g].pc = aguPc[g];
        assign agu[g].compressed = aguCompressed[g];

        // The early path goes straight to the cache and is never held
        assign early[g].stall = 1'b0;
        assign late[g].stall = stall[g];

        assign earlyValid[g] = early[g].valid;
        assign earlyAddr[g] = early[g].addr;
        assign earlySize[g] = early[g].size;
        assign earlyLoadSqN[g] = early[g].loadSqN;
        assign earlyTag[g] = early[g].tagDst;

        assign lateValid[g] = late[g].valid;
        assign lateAddr[g] = late[g].addr;
        assign lateSize[g] = late[g].size;
        assign lateLoadSqN[g] = late[g].loadSqN;
        assign lateTag[g] = late[g].tagDst;
        assign lateIsMmio[g] = late[g].isMmio;
    end

    loadBuffer loadBuffer_i (
        .clk(clk),
        .rst(rst),
        .agu(agu),
        .early(early),
        .late(late),
        .ackValid(ackValid),
        .ackFail(ackFail),
        .ackLoadSqN(ackLoadSqN),
        .comLoadSqN(comLoadSqN),
        .comSqN(comSqN),
        .sqDone(sqDone),
        .brTaken(brTaken),
        .brFlush(brFlush),
        .brSqN(brSqN),
        .brLoadSqN(brLoadSqN),
        .redirTaken(redirTaken),
        .redirPc(redirPc),
        .redirSqN(redirSqN),
        .redirLoadSqN(redirLoadSqN),
        .maxLoadSqN(maxLoadSqN)
    );

endmodule

`default_nettype wire

//--- verification/tbMemLoadUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "memUnit_defs.svh"

module tbMemLoadUnit;
    import memUnitPkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int FIELDS = 38;
    localparam int MAX_LINES = 64;
    // Column offsets inside one trace line
    localparam int COL_PORT = 1;
    localparam int COL_PC = 13;
    localparam int COL_ACK = 15;
    localparam int COL_STALL = 18;
    localparam int COL_COM = 19;
    localparam int COL_BR = 22;
    localparam int COL_EXP = 26;
    // Every access in the trace is a full word
    localparam AccessSize WORD_SIZE = 2'd2;

    logic clk;
    logic rst;
    logic aguValid[`NUM_AGUS];
    logic aguIsLoad[`NUM_AGUS];
    MemAddr aguAddr[`NUM_AGUS];
    AccessSize aguSize[`NUM_AGUS];
    logic aguSignExtend[`NUM_AGUS];
    SqN aguSqN[`NUM_AGUS];
    SqN aguLoadSqN[`NUM_AGUS];
    Tag aguTag[`NUM_AGUS];
    logic aguDoNotCommit[`NUM_AGUS];
    logic aguEarlyFail[`NUM_AGUS];
    AguExc aguExc[`NUM_AGUS];
    MemAddr aguPc[`NUM_AGUS];
    logic aguCompressed[`NUM_AGUS];
    logic ackValid[`NUM_AGUS];
    logic ackFail[`NUM_AGUS];
    SqN ackLoadSqN[`NUM_AGUS];
    logic stall[`NUM_AGUS];
    SqN comLoadSqN;
    SqN comSqN;
    logic sqDone;
    logic brTaken;
    logic brFlush;
    SqN brSqN;
    SqN brLoadSqN;
    logic earlyValid[`NUM_AGUS];
    MemAddr earlyAddr[`NUM_AGUS];
    AccessSize earlySize[`NUM_AGUS];
    SqN earlyLoadSqN[`NUM_AGUS];
    Tag earlyTag[`NUM_AGUS];
    logic lateValid[`NUM_AGUS];
    MemAddr lateAddr[`NUM_AGUS];
    AccessSize lateSize[`NUM_AGUS];
    SqN lateLoadSqN[`NUM_AGUS];
    Tag lateTag[`NUM_AGUS];
    logic lateIsMmio[`NUM_AGUS];
    logic redirTaken;
    MemAddr redirPc;
    SqN redirSqN;
    SqN redirLoadSqN;
    SqN maxLoadSqN;

    logic [31:0] traceMem[0:FIELDS*MAX_LINES-1];
    int numLines = 0;

    memLoadUnit memLoadUnit_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] field(input int line, input int col);
        return traceMem[line * FIELDS + col];
    endfunction

    function automatic logic flag(input int line, input int col);
        return field(line, col) != 32'd0;
    endfunction

    // The redirect resumes after the store, one loadSqN further when the store does not commit
    function automatic SqN redirectLoadSqN(input int line);
        SqN expected;
        int base;
        expected = '0;
        for (int p = 0; p < `NUM_AGUS; p++) begin
            base = COL_PORT + 6 * p;
            if (line > 0 && flag(line - 1, base) && !flag(line - 1, base + 1))
                expected = SqN'(field(line - 1, base + 4)) + SqN'(aguDoNotCommit[p]);
        end
        return expected;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic valueError(input string name, input logic [31:0] actual,
        input logic [31:0] expected);
        failRun($sformatf("error at %0d ns: %s is %h, expected %h", $time, name, actual,
            expected));
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            valueError(name, 32'(actual), 32'(expected));
    endtask

    task automatic checkLoad(input string kind, input int p, input MemAddr addr,
        input AccessSize size, input SqN loadSqN, input Tag tag, input MemAddr expAddr,
        input AccessSize expSize, input SqN expLoadSqN, input Tag expTag);
        if (addr !== expAddr)
            valueError($sformatf("%sAddr[%0d]", kind, p), addr, expAddr);
        if (size !== expSize)
            valueError($sformatf("%sSize[%0d]", kind, p), 32'(size), 32'(expSize));
        if (loadSqN !== expLoadSqN)
            valueError($sformatf("%sLoadSqN[%0d]", kind, p), 32'(loadSqN), 32'(expLoadSqN));
        if (tag !== expTag)
            valueError($sformatf("%sTag[%0d]", kind, p), 32'(tag), 32'(expTag));
    endtask

    task automatic checkRedirect(input MemAddr pc, input SqN sqN, input SqN loadSqN,
        input MemAddr expPc, input SqN expSqN, input SqN expLoadSqN);
        if (pc !== expPc)
            valueError("redirPc", pc, expPc);
        if (sqN !== expSqN)
            valueError("redirSqN", 32'(sqN), 32'(expSqN));
        if (loadSqN !== expLoadSqN)
            valueError("redirLoadSqN", 32'(loadSqN), 32'(expLoadSqN));
    endtask

    task automatic checkLimit(input SqN limit, input SqN expLimit);
        if (limit !== expLimit)
            valueError("maxLoadSqN", 32'(limit), 32'(expLimit));
    endtask

    task automatic applyIdle();
        for (int p = 0; p < `NUM_AGUS; p++) begin
            aguValid[p] <= 1'b0;
            aguIsLoad[p] <= 1'b0;
            aguAddr[p] <= '0;
            aguSize[p] <= WORD_SIZE;
            aguSignExtend[p] <= 1'b0;
            aguSqN[p] <= '0;
            aguLoadSqN[p] <= '0;
            aguTag[p] <= '0;
            aguDoNotCommit[p] <= 1'b0;
            aguEarlyFail[p] <= 1'b0;
            aguExc[p] <= AGU_NO_EXCEPTION;
            aguPc[p] <= '0;
            aguCompressed[p] <= 1'b0;
            ackValid[p] <= 1'b0;
            ackFail[p] <= 1'b0;
            ackLoadSqN[p] <= '0;
            stall[p] <= 1'b0;
        end
        comLoadSqN <= '0;
        comSqN <= '0;
        sqDone <= 1'b0;
        brTaken <= 1'b0;
        brFlush <= 1'b0;
        brSqN <= '0;
        brLoadSqN <= '0;
    endtask

    task automatic applyLine(input int line);
        int base;
        for (int p = 0; p < `NUM_AGUS; p++) begin
            base = COL_PORT + 6 * p;
            aguValid[p] <= flag(line, base);
            aguIsLoad[p] <= flag(line, base + 1);
            aguAddr[p] <= field(line, base + 2);
            aguSqN[p] <= SqN'(field(line, base + 3));
            aguLoadSqN[p] <= SqN'(field(line, base + 4));
            aguTag[p] <= Tag'(field(line, base + 5));
            aguPc[p] <= field(line, COL_PC);
            aguCompressed[p] <= flag(line, COL_PC + 1);
            stall[p] <= flag(line, COL_STALL);
        end
        // Nacks come back on port 0 only in this trace
        ackValid[0] <= flag(line, COL_ACK);
        ackFail[0] <= flag(line, COL_ACK + 1);
        ackLoadSqN[0] <= SqN'(field(line, COL_ACK + 2));
        comLoadSqN <= SqN'(field(line, COL_COM));
        comSqN <= SqN'(field(line, COL_COM + 1));
        sqDone <= flag(line, COL_COM + 2);
        brTaken <= flag(line, COL_BR);
        brFlush <= flag(line, COL_BR + 1);
        brSqN <= SqN'(field(line, COL_BR + 2));
        brLoadSqN <= SqN'(field(line, COL_BR + 3));
    endtask

    task automatic checkLine(input int line);
        for (int p = 0; p < `NUM_AGUS; p++) begin
            checkFlag($sformatf("earlyValid[%0d]", p), earlyValid[p], flag(line, COL_EXP + p));
            // An early request carries the AGU operation unchanged
            if (flag(line, COL_EXP + p))
                checkLoad("early", p, earlyAddr[p], earlySize[p], earlyLoadSqN[p], earlyTag[p],
                    field(line, COL_PORT + 6 * p + 2), WORD_SIZE,
                    SqN'(field(line, COL_PORT + 6 * p + 4)),
                    Tag'(field(line, COL_PORT + 6 * p + 5)));
            checkFlag($sformatf("lateValid[%0d]", p), lateValid[p], flag(line, COL_EXP + 2 + p));
        end
        if (flag(line, COL_EXP + 2)) begin
            checkLoad("late", 0, lateAddr[0], lateSize[0], lateLoadSqN[0], lateTag[0],
                field(line, COL_EXP + 4), WORD_SIZE, SqN'(field(line, COL_EXP + 5)),
                Tag'(field(line, COL_EXP + 6)));
            checkFlag("lateIsMmio[0]", lateIsMmio[0], flag(line, COL_EXP + 7));
        end
        checkFlag("redirTaken", redirTaken, flag(line, COL_EXP + 8));
        if (flag(line, COL_EXP + 8))
            checkRedirect(redirPc, redirSqN, redirLoadSqN, field(line, COL_EXP + 9),
                SqN'(field(line, COL_EXP + 10)), redirectLoadSqN(line));
        checkLimit(maxLoadSqN, SqN'(field(line, COL_EXP + 11)));
    endtask

    initial begin
        int count;
        clk = 1'b0;
        rst <= 1'b1;
        applyIdle();
        $readmemh("verification/loadTrace.txt", traceMem);
        count = 0;
        while (count < MAX_LINES && field(count, 0) == 32'hc)
            count++;
        if (count == 0 || count == MAX_LINES || field(count, 0) != 32'he)
            failRun("the trace file is empty or has no end marker after its last cycle");
        numLines = count;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // Inputs change on the rising edge, outputs are sampled on the falling edge
        for (int line = 0; line < numLines; line++) begin
            @(posedge clk);
            applyLine(line);
            @(negedge clk);
            checkLine(line);
        end
        $display("No errors");
        $finish;
    end

    initial begin
        wait (numLines > 0);
        #((RESET_CYCLES + numLines + 16) * CLK_PERIOD);
        failRun("timeout: the trace did not finish within the expected number of cycles");
    end

endmodule

`default_nettype wire

//--- verification/loadTrace.txt
// c = cycle, e = end | v0 ld0 addr0 sq0 lsq0 tag0 | v1 ld1 addr1 sq1 lsq1 tag1 | pc cmp | ack fail acklsq stall
// | comlsq comsq sqdone | br flush brsq brlsq | expected: ev0 ev1 lv0 lv1 laddr llsq ltag lmmio
// | redir rpc rsq | maxlsq (late, redirect and limit show the state after the previous edge)
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  0 0 0  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  7
c 1 1 300 2 0 11  0 0 0 0 0 0  0 0  0 0 0 0  0 0 0  0 0 0 0  1 0 0 0 0 0 0 0  0 0 0  7
c 1 1 200 4 1 12  1 0 200 3 1 0  0 0  0 0 0 0  0 0 0  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  7
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 1  0 0 0  0 0 0 0  0 0 1 0 200 1 12 0  0 0 0  7
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  0 0 0  0 0 0 0  0 0 1 0 200 1 12 0  0 0 0  7
c 0 0 0 0 0 0  1 0 300 1 0 0  80 0  0 0 0 0  0 0 0  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  7
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  1 1 1 0  0 0 0  0 0 0 0  0 0 0 0 0 0 0 0  1 84 1  7
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  0 0 0  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  7
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  0 0 0  0 0 0 0  0 0 1 0 200 1 12 0  0 0 0  7
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  2 5 0  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  7
c 1 1 10000000 6 2 13  0 0 0 0 0 0  0 0  0 0 0 0  2 5 0  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  9
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  2 5 0  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  9
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  2 6 0  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  9
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  2 6 1  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  9
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  2 6 1  0 0 0 0  0 0 1 0 10000000 2 13 1  0 0 0  9
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  3 7 1  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  9
c 1 1 400 8 3 14  1 1 500 9 4 15  0 0  0 0 0 0  3 7 1  0 0 0 0  1 1 0 0 0 0 0 0  0 0 0  a
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  3 7 1  1 0 8 4  0 0 0 0 0 0 0 0  0 0 0  a
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  1 1 4 0  3 7 1  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  a
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  1 1 3 0  3 7 1  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  a
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  3 7 1  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  a
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  3 7 1  0 0 0 0  0 0 1 0 400 3 14 0  0 0 0  a
c 0 0 0 0 0 0  1 0 400 7 3 0  90 1  0 0 0 0  3 7 1  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  a
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  3 7 1  0 0 0 0  0 0 0 0 0 0 0 0  1 92 7  a
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  4 a 1  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  a
c 0 0 0 0 0 0  0 0 0 0 0 0  0 0  0 0 0 0  4 a 1  0 0 0 0  0 0 0 0 0 0 0 0  0 0 0  b
e

//--- filelist.f
+incdir+design
design/memUnitPkg.sv
design/aguOpIf.sv
design/loadIssueIf.sv
design/forwardHazardDetect.sv
design/lateIssueSelect.sv
design/squashMaskGen.sv
design/loadBuffer.sv
design/memLoadUnit.sv
verification/tbMemLoadUnit.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tbMemLoadUnit -f filelist.f &&
./obj_dir/VtbMemLoadUnit | tee /dev/stderr | grep -qx "No errors" || exit 1
